// File: common/axi_reqrsp_pkg.sv
// Widths, channel structs, enums and address helpers for the AXI to reqrsp bridge.
package axi_reqrsp_pkg;

  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned StrbWidth     = 4;
  localparam int unsigned IdWidth       = 4;
  localparam int unsigned LenWidth      = 8;
  localparam int unsigned SizeWidth     = 3;
  localparam int unsigned QosWidth      = 4;
  // Expected downstream latency in cycles.
  localparam int unsigned BufDepth      = 2;
  localparam int unsigned MetaFifoDepth = BufDepth + 1;
  localparam int unsigned MetaPtrWidth  = $clog2(MetaFifoDepth);
  localparam int unsigned MetaCntWidth  = $clog2(MetaFifoDepth + 1);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [LenWidth-1:0]  len_t;
  typedef logic [SizeWidth-1:0] size_t;
  typedef logic [QosWidth-1:0]  qos_t;

  // AXI response encoding, only the two codes this bridge emits.
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  typedef enum logic {
    SEL_READ  = 1'b0,
    SEL_WRITE = 1'b1
  } arb_sel_e;

  // Shared by AW and AR.
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    size_t size;
    qos_t  qos;
  } axi_ax_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } axi_b_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    logic  last;
    resp_e resp;
  } axi_r_t;

  // One entry per memory beat, kept until its response returns.
  typedef struct packed {
    addr_t addr;
    id_t   id;
    logic  last;
    qos_t  qos;
    size_t size;
    logic  write;
  } meta_t;

  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t data;
    strb_t strb;
    size_t size;
  } reqrsp_q_t;

  typedef struct packed {
    data_t data;
    logic  error;
  } reqrsp_p_t;

  function automatic addr_t num_bytes(size_t size);
    return addr_t'(1) << size;
  endfunction

  function automatic addr_t aligned_addr(addr_t addr, size_t size);
    return addr & ~(num_bytes(size) - addr_t'(1));
  endfunction

endpackage

// File: burst/axi_rd_burst.sv
// Read burst generator: AR acceptance, beat counter and per-beat address.
`timescale 1ns/1ps

module axi_rd_burst (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    ar_valid_i,
  input  axi_reqrsp_pkg::axi_ax_t ar_i,
  input  logic                    rd_ready_i,
  output logic                    ar_ready_o,
  output logic                    rd_valid_o,
  output axi_reqrsp_pkg::meta_t   rd_meta_o,
  output logic                    rd_active_o
);
  import axi_reqrsp_pkg::*;

  len_t  cnt_d, cnt_q;
  meta_t beat_d, beat_q;

  // Beats still to come after the one at beat_q.addr.
  assign rd_active_o = (cnt_q != '0);

  always_comb begin
    ar_ready_o = 1'b0;
    rd_valid_o = 1'b0;
    rd_meta_o  = '0;
    cnt_d      = cnt_q;
    beat_d     = beat_q;
    if (cnt_q != '0) begin
      // Later beats step from the aligned base.
      rd_valid_o     = 1'b1;
      rd_meta_o      = beat_q;
      rd_meta_o.addr = beat_q.addr + num_bytes(beat_q.size);
      rd_meta_o.last = (cnt_q == len_t'(1));
      if (rd_ready_i) begin
        cnt_d       = cnt_q - len_t'(1);
        beat_d.addr = rd_meta_o.addr;
      end
    end else if (ar_valid_i) begin
      // First beat goes out with the raw address.
      rd_valid_o = 1'b1;
      rd_meta_o  = '{
        addr:  ar_i.addr,
        id:    ar_i.id,
        last:  (ar_i.len == '0),
        qos:   ar_i.qos,
        size:  ar_i.size,
        write: 1'b0
      };
      if (rd_ready_i) begin
        ar_ready_o  = 1'b1;
        cnt_d       = ar_i.len;
        beat_d      = rd_meta_o;
        beat_d.addr = aligned_addr(ar_i.addr, ar_i.size);
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    beat_q <= beat_d;
  end

endmodule

// File: burst/axi_wr_burst.sv
// Write burst generator: AW and W acceptance, beat counter and per-beat address.
`timescale 1ns/1ps

module axi_wr_burst (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    aw_valid_i,
  input  axi_reqrsp_pkg::axi_ax_t aw_i,
  input  logic                    w_valid_i,
  input  axi_reqrsp_pkg::axi_w_t  w_i,
  input  logic                    wr_ready_i,
  output logic                    aw_ready_o,
  output logic                    w_ready_o,
  output logic                    wr_valid_o,
  output axi_reqrsp_pkg::meta_t   wr_meta_o,
  output logic                    wr_active_o
);
  import axi_reqrsp_pkg::*;

  len_t  cnt_d, cnt_q;
  meta_t beat_d, beat_q;

  assign wr_active_o = (cnt_q != '0);

  always_comb begin
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    wr_valid_o = 1'b0;
    wr_meta_o  = '0;
    cnt_d      = cnt_q;
    beat_d     = beat_q;
    if (cnt_q != '0) begin
      // A beat is only offered together with its W data.
      if (w_valid_i) begin
        wr_valid_o     = 1'b1;
        wr_meta_o      = beat_q;
        wr_meta_o.addr = beat_q.addr + num_bytes(beat_q.size);
        wr_meta_o.last = (cnt_q == len_t'(1)) | w_i.last;
        if (wr_ready_i) begin
          w_ready_o   = 1'b1;
          // A W beat flagged last also closes the burst.
          cnt_d       = w_i.last ? '0 : cnt_q - len_t'(1);
          beat_d.addr = wr_meta_o.addr;
        end
      end
    end else if (aw_valid_i && w_valid_i) begin
      wr_valid_o = 1'b1;
      wr_meta_o  = '{
        addr:  aw_i.addr,
        id:    aw_i.id,
        last:  (aw_i.len == '0) | w_i.last,
        qos:   aw_i.qos,
        size:  aw_i.size,
        write: 1'b1
      };
      if (wr_ready_i) begin
        aw_ready_o  = 1'b1;
        w_ready_o   = 1'b1;
        cnt_d       = w_i.last ? '0 : aw_i.len;
        beat_d      = wr_meta_o;
        beat_d.addr = aligned_addr(aw_i.addr, aw_i.size);
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    beat_q <= beat_d;
  end

endmodule

// File: logic/ax_arbiter.sv
// Read/write arbiter with QoS priority and select lock, forked to reqrsp q and metadata.
`timescale 1ns/1ps

module ax_arbiter (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      rd_valid_i,
  input  axi_reqrsp_pkg::meta_t     rd_meta_i,
  input  logic                      rd_active_i,
  input  logic                      wr_valid_i,
  input  axi_reqrsp_pkg::meta_t     wr_meta_i,
  input  logic                      wr_active_i,
  input  axi_reqrsp_pkg::axi_w_t    w_i,
  input  logic                      q_ready_i,
  input  logic                      fifo_ready_i,
  output logic                      rd_ready_o,
  output logic                      wr_ready_o,
  output logic                      q_valid_o,
  output axi_reqrsp_pkg::reqrsp_q_t q_o,
  output logic                      fifo_valid_o,
  output axi_reqrsp_pkg::meta_t     fifo_meta_o
);
  import axi_reqrsp_pkg::*;

  arb_sel_e sel_d, sel_q;
  logic     lock_d, lock_q;
  logic     arb_valid, arb_ready;
  meta_t    arb_meta;
  logic     q_done_q, fifo_done_q;
  logic     q_acc, fifo_acc;

  always_comb begin
    sel_d = sel_q;
    if (!lock_q) begin
      if (rd_valid_i ^ wr_valid_i) begin
        sel_d = wr_valid_i ? SEL_WRITE : SEL_READ;
      end else if (rd_valid_i && wr_valid_i) begin
        if (wr_meta_i.qos > rd_meta_i.qos) begin
          sel_d = SEL_WRITE;
        end else if (rd_meta_i.qos > wr_meta_i.qos) begin
          sel_d = SEL_READ;
        end else if (wr_meta_i.last && !rd_meta_i.last) begin
          // Single write first, write bursts cannot interleave.
          sel_d = SEL_WRITE;
        end else if (wr_active_i) begin
          sel_d = SEL_WRITE;
        end else if (rd_active_i) begin
          sel_d = SEL_READ;
        end else begin
          sel_d = (sel_q == SEL_READ) ? SEL_WRITE : SEL_READ;
        end
      end
    end
  end

  assign arb_valid  = (sel_d == SEL_WRITE) ? wr_valid_i : rd_valid_i;
  assign arb_meta   = (sel_d == SEL_WRITE) ? wr_meta_i : rd_meta_i;
  assign rd_ready_o = (sel_d == SEL_READ) & arb_ready;
  assign wr_ready_o = (sel_d == SEL_WRITE) & arb_ready;

  // Hold the choice until the fork has taken the item on both sides.
  assign lock_d = arb_valid & ~arb_ready;

  // Two-way fork, each side remembers an earlier acceptance.
  assign q_valid_o    = arb_valid & ~q_done_q;
  assign fifo_valid_o = arb_valid & ~fifo_done_q;
  assign q_acc        = q_done_q | q_ready_i;
  assign fifo_acc     = fifo_done_q | fifo_ready_i;
  assign arb_ready    = q_acc & fifo_acc;

  assign fifo_meta_o = arb_meta;
  assign q_o = '{
    addr:  arb_meta.addr,
    write: arb_meta.write,
    data:  arb_meta.write ? w_i.data : '0,
    strb:  arb_meta.write ? w_i.strb : '0,
    size:  arb_meta.size
  };

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q       <= SEL_READ;
      lock_q      <= 1'b0;
      q_done_q    <= 1'b0;
      fifo_done_q <= 1'b0;
    end else begin
      sel_q  <= sel_d;
      lock_q <= lock_d;
      if (arb_valid && !arb_ready) begin
        q_done_q    <= q_acc;
        fifo_done_q <= fifo_acc;
      end else begin
        q_done_q    <= 1'b0;
        fifo_done_q <= 1'b0;
      end
    end
  end

endmodule

// File: logic/resp_meta_fifo.sv
// Fall-through FIFO holding the metadata of beats in flight downstream.
`timescale 1ns/1ps

module resp_meta_fifo (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  push_valid_i,
  input  axi_reqrsp_pkg::meta_t push_meta_i,
  input  logic                  pop_ready_i,
  output logic                  push_ready_o,
  output logic                  pop_valid_o,
  output axi_reqrsp_pkg::meta_t pop_meta_o
);
  import axi_reqrsp_pkg::*;

  meta_t                   mem_q [MetaFifoDepth];
  logic [MetaPtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [MetaCntWidth-1:0] cnt_q;
  logic                    empty, push, pop, bypass;

  assign empty        = (cnt_q == '0);
  assign push_ready_o = (cnt_q != MetaCntWidth'(MetaFifoDepth));
  // An empty buffer passes the pushed entry straight through.
  assign pop_valid_o  = ~empty | push_valid_i;
  assign pop_meta_o   = empty ? push_meta_i : mem_q[rd_ptr_q];
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;
  assign bypass       = empty & push & pop;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (!bypass) begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == MetaPtrWidth'(MetaFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == MetaPtrWidth'(MetaFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + MetaCntWidth'(push) - MetaCntWidth'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && !bypass) begin
      mem_q[wr_ptr_q] <= push_meta_i;
    end
  end

endmodule

// File: logic/resp_router.sv
// Response path: joins memory responses with buffered metadata and steers them to R or B.
`timescale 1ns/1ps

module resp_router (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      fifo_valid_i,
  input  axi_reqrsp_pkg::meta_t     fifo_meta_i,
  input  logic                      p_valid_i,
  input  axi_reqrsp_pkg::reqrsp_p_t p_i,
  input  logic                      r_ready_i,
  input  logic                      b_ready_i,
  output logic                      fifo_ready_o,
  output logic                      p_ready_o,
  output logic                      r_valid_o,
  output axi_reqrsp_pkg::axi_r_t    r_o,
  output logic                      b_valid_o,
  output axi_reqrsp_pkg::axi_b_t    b_o
);
  import axi_reqrsp_pkg::*;

  logic  head_valid, head_ready;
  meta_t head;
  logic  sel_r, sel_b;
  logic  join_valid, join_ready;
  resp_e resp;

  resp_meta_fifo u_meta_fifo (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .push_valid_i (fifo_valid_i),
    .push_meta_i  (fifo_meta_i),
    .pop_ready_i  (head_ready),
    .push_ready_o (fifo_ready_o),
    .pop_valid_o  (head_valid),
    .pop_meta_o   (head)
  );

  // Reads answer every beat, writes only on the last.
  assign sel_r = ~head.write;
  assign sel_b = head.write & head.last;

  assign join_valid = p_valid_i & head_valid;
  assign r_valid_o  = join_valid & sel_r;
  assign b_valid_o  = join_valid & sel_b;

  // Inner write beats drain without an output.
  always_comb begin
    if (sel_r) begin
      join_ready = r_ready_i;
    end else if (sel_b) begin
      join_ready = b_ready_i;
    end else begin
      join_ready = 1'b1;
    end
  end

  assign p_ready_o  = head_valid & join_ready;
  assign head_ready = p_valid_i & join_ready;

  assign resp = p_i.error ? SLVERR : OKAY;

  assign r_o = '{
    data: p_i.data,
    id:   head.id,
    last: head.last,
    resp: resp
  };
  assign b_o = '{
    id:   head.id,
    resp: resp
  };

endmodule

// File: logic/axi_to_reqrsp.sv
// Top level of the AXI4 to reqrsp bridge: burst generators, arbiter, response router and busy.
`timescale 1ns/1ps

module axi_to_reqrsp (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      aw_valid_i,
  input  axi_reqrsp_pkg::axi_ax_t   aw_i,
  input  logic                      w_valid_i,
  input  axi_reqrsp_pkg::axi_w_t    w_i,
  input  logic                      ar_valid_i,
  input  axi_reqrsp_pkg::axi_ax_t   ar_i,
  input  logic                      b_ready_i,
  input  logic                      r_ready_i,
  input  logic                      q_ready_i,
  input  logic                      p_valid_i,
  input  axi_reqrsp_pkg::reqrsp_p_t p_i,
  output logic                      aw_ready_o,
  output logic                      w_ready_o,
  output logic                      ar_ready_o,
  output logic                      b_valid_o,
  output axi_reqrsp_pkg::axi_b_t    b_o,
  output logic                      r_valid_o,
  output axi_reqrsp_pkg::axi_r_t    r_o,
  output logic                      q_valid_o,
  output axi_reqrsp_pkg::reqrsp_q_t q_o,
  output logic                      p_ready_o,
  output logic                      busy_o
);
  import axi_reqrsp_pkg::*;

  logic  rd_valid, rd_ready, rd_active;
  logic  wr_valid, wr_ready, wr_active;
  meta_t rd_meta, wr_meta;
  logic  fifo_valid, fifo_ready;
  meta_t fifo_meta;

  axi_rd_burst u_rd_burst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ar_valid_i  (ar_valid_i),
    .ar_i        (ar_i),
    .rd_ready_i  (rd_ready),
    .ar_ready_o  (ar_ready_o),
    .rd_valid_o  (rd_valid),
    .rd_meta_o   (rd_meta),
    .rd_active_o (rd_active)
  );

  axi_wr_burst u_wr_burst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .aw_valid_i  (aw_valid_i),
    .aw_i        (aw_i),
    .w_valid_i   (w_valid_i),
    .w_i         (w_i),
    .wr_ready_i  (wr_ready),
    .aw_ready_o  (aw_ready_o),
    .w_ready_o   (w_ready_o),
    .wr_valid_o  (wr_valid),
    .wr_meta_o   (wr_meta),
    .wr_active_o (wr_active)
  );

  // W data reaches the q channel through the arbiter.
  ax_arbiter u_arbiter (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .rd_valid_i   (rd_valid),
    .rd_meta_i    (rd_meta),
    .rd_active_i  (rd_active),
    .wr_valid_i   (wr_valid),
    .wr_meta_i    (wr_meta),
    .wr_active_i  (wr_active),
    .w_i          (w_i),
    .q_ready_i    (q_ready_i),
    .fifo_ready_i (fifo_ready),
    .rd_ready_o   (rd_ready),
    .wr_ready_o   (wr_ready),
    .q_valid_o    (q_valid_o),
    .q_o          (q_o),
    .fifo_valid_o (fifo_valid),
    .fifo_meta_o  (fifo_meta)
  );

  resp_router u_resp_router (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .fifo_valid_i (fifo_valid),
    .fifo_meta_i  (fifo_meta),
    .p_valid_i    (p_valid_i),
    .p_i          (p_i),
    .r_ready_i    (r_ready_i),
    .b_ready_i    (b_ready_i),
    .fifo_ready_o (fifo_ready),
    .p_ready_o    (p_ready_o),
    .r_valid_o    (r_valid_o),
    .r_o          (r_o),
    .b_valid_o    (b_valid_o),
    .b_o          (b_o)
  );

  // Busy while any AXI channel is pending or a burst is open.
  assign busy_o = aw_valid_i | w_valid_i | ar_valid_i | b_valid_o | r_valid_o |
                  rd_active | wr_active;

endmodule

// File: test/tb_reqrsp_mem.sv
// Behavioral reqrsp memory for the testbench with sparse storage, strobed writes and random latency.
`timescale 1ns/1ps

module tb_reqrsp_mem (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      q_valid_i,
  input  axi_reqrsp_pkg::reqrsp_q_t q_i,
  input  logic                      p_ready_i,
  output logic                      q_ready_o,
  output logic                      p_valid_o,
  output axi_reqrsp_pkg::reqrsp_p_t p_o
);
  import axi_reqrsp_pkg::*;

  data_t       mem [addr_t];
  integer      seed = 32'h1d62;
  logic [31:0] rand_word;
  logic        pend_q;
  logic [1:0]  delay_q;
  reqrsp_p_t   rsp_q;

  // Untouched words read back a value tied to their address.
  function automatic data_t fill_word(addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5a5a_a5a5;
  endfunction

  function automatic data_t read_word(addr_t a);
    if (mem.exists(a >> 2)) begin
      return mem[a >> 2];
    end
    return fill_word(a);
  endfunction

  // One request at a time, so responses stay in order.
  assign q_ready_o = ~pend_q;
  assign p_valid_o = pend_q & (delay_q == 2'd0);
  assign p_o       = rsp_q;

  always @(posedge clk_i or negedge arst_n_i) begin
    data_t word;
    int    i;
    if (!arst_n_i) begin
      pend_q  <= 1'b0;
      delay_q <= '0;
      rsp_q   <= '0;
    end else if (pend_q) begin
      if (delay_q != 2'd0) begin
        delay_q <= delay_q - 2'd1;
      end else if (p_ready_i) begin
        pend_q <= 1'b0;
      end
    end else if (q_valid_i) begin
      rand_word = $random(seed);
      pend_q  <= 1'b1;
      delay_q <= rand_word[1:0];
      if (q_i.addr[31]) begin
        // Upper half of the address space is not backed.
        rsp_q <= '{data: '0, error: 1'b1};
      end else if (q_i.write) begin
        word = read_word(q_i.addr);
        for (i = 0; i < StrbWidth; i++) begin
          if (q_i.strb[i]) begin
            word[8*i +: 8] = q_i.data[8*i +: 8];
          end
        end
        mem[q_i.addr >> 2] = word;
        rsp_q <= '{data: '0, error: 1'b0};
      end else begin
        rsp_q <= '{data: read_word(q_i.addr), error: 1'b0};
      end
    end
  end

endmodule

// File: test/tb_axi_to_reqrsp.sv
// Testbench for the AXI to reqrsp bridge with clock, reset, AXI driver, reference model and checks.
`timescale 1ns/1ps

module tb_axi_to_reqrsp;
  import axi_reqrsp_pkg::*;

  localparam int unsigned TimeoutCycles = 400;
  localparam int unsigned DriveDelay    = 1;

  logic        clk, arst_n;
  logic        aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
  axi_ax_t     aw, ar;
  axi_w_t      w;
  logic        b_valid, b_ready, r_valid, r_ready;
  axi_b_t      b;
  axi_r_t      r;
  logic        q_valid, q_ready, p_valid, p_ready, busy;
  reqrsp_q_t   q;
  reqrsp_p_t   p;

  axi_r_t      exp_r [$];
  axi_b_t      exp_b [$];
  reqrsp_q_t   q_log [$];
  data_t       shadow [addr_t];
  data_t       beat_data [16];
  strb_t       beat_strb [16];
  int unsigned check_count = 0;
  int unsigned err_count   = 0;
  int unsigned test_count  = 0;
  int unsigned b_count     = 0;
  logic        random_r_ready = 1'b0;
  integer      seed = 32'h1d62;
  logic [31:0] rand_word;

  axi_to_reqrsp dut (
    .clk_i (clk), .arst_n_i (arst_n),
    .aw_valid_i (aw_valid), .aw_i (aw), .w_valid_i (w_valid), .w_i (w),
    .ar_valid_i (ar_valid), .ar_i (ar), .b_ready_i (b_ready), .r_ready_i (r_ready),
    .q_ready_i (q_ready), .p_valid_i (p_valid), .p_i (p),
    .aw_ready_o (aw_ready), .w_ready_o (w_ready), .ar_ready_o (ar_ready),
    .b_valid_o (b_valid), .b_o (b), .r_valid_o (r_valid), .r_o (r),
    .q_valid_o (q_valid), .q_o (q), .p_ready_o (p_ready), .busy_o (busy)
  );

  tb_reqrsp_mem u_mem (
    .clk_i (clk), .arst_n_i (arst_n),
    .q_valid_i (q_valid), .q_i (q), .p_ready_i (p_ready),
    .q_ready_o (q_ready), .p_valid_o (p_valid), .p_o (p)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // R back-pressure, random only while a test asks for it.
  always @(posedge clk) begin
    #(DriveDelay);
    rand_word = $random(seed);
    r_ready = random_r_ready ? (rand_word[1:0] != 2'b00) : 1'b1;
  end

  task automatic abort_run(string what);
    $display("Timeout: %s", what);
    $display("Regression failed");
    $finish;
  endtask

  task automatic compare_field(string name, logic [63:0] exp, logic [63:0] got);
    check_count++;
    if (exp !== got) begin
      err_count++;
      $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_r(axi_r_t exp, axi_r_t got);
    compare_field("r_o.data", exp.data, got.data);
    compare_field("r_o.id", exp.id, got.id);
    compare_field("r_o.last", exp.last, got.last);
    compare_field("r_o.resp", exp.resp, got.resp);
  endtask

  task automatic check_b(axi_b_t exp, axi_b_t got);
    compare_field("b_o.id", exp.id, got.id);
    compare_field("b_o.resp", exp.resp, got.resp);
  endtask

  task automatic check_q(reqrsp_q_t exp, reqrsp_q_t got);
    compare_field("q_o.addr", exp.addr, got.addr);
    compare_field("q_o.write", exp.write, got.write);
    compare_field("q_o.data", exp.data, got.data);
    compare_field("q_o.strb", exp.strb, got.strb);
    compare_field("q_o.size", exp.size, got.size);
  endtask

  function automatic data_t fill_word(addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5a5a_a5a5;
  endfunction

  function automatic data_t shadow_word(addr_t a);
    if (shadow.exists(a >> 2)) begin
      return shadow[a >> 2];
    end
    return fill_word(a);
  endfunction

  function automatic void write_shadow(addr_t a, data_t data, strb_t strb);
    data_t word;
    int    i;
    word = shadow_word(a);
    for (i = 0; i < StrbWidth; i++) begin
      if (strb[i]) begin
        word[8*i +: 8] = data[8*i +: 8];
      end
    end
    shadow[a >> 2] = word;
  endfunction

  // Expected read beat, errors carry zero data.
  function automatic axi_r_t ref_read(addr_t a, id_t id, logic last);
    axi_r_t exp;
    exp.id   = id;
    exp.last = last;
    if (a[31]) begin
      exp.data = '0;
      exp.resp = SLVERR;
    end else begin
      exp.data = shadow_word(a);
      exp.resp = OKAY;
    end
    return exp;
  endfunction

  function automatic axi_ax_t make_ax(id_t id, addr_t addr, len_t len, qos_t qos);
    axi_ax_t ax;
    ax.id   = id;
    ax.addr = addr;
    ax.len  = len;
    ax.size = 3'd2;
    ax.qos  = qos;
    return ax;
  endfunction

  function automatic reqrsp_q_t make_q(addr_t addr, logic write, data_t data, strb_t strb);
    reqrsp_q_t req;
    req.addr  = addr;
    req.write = write;
    req.data  = data;
    req.strb  = strb;
    req.size  = 3'd2;
    return req;
  endfunction

  always @(negedge clk) begin
    axi_r_t exp_beat;
    axi_b_t exp_resp;
    if (r_valid && r_ready) begin
      if (exp_r.size() == 0) begin
        err_count++;
        $display("R beat with id %h arrived at %0t with no read outstanding", r.id, $time);
      end else begin
        exp_beat = exp_r.pop_front();
        check_r(exp_beat, r);
      end
    end
    if (b_valid && b_ready) begin
      b_count++;
      if (exp_b.size() == 0) begin
        err_count++;
        $display("B with id %h arrived at %0t with no write outstanding", b.id, $time);
      end else begin
        exp_resp = exp_b.pop_front();
        check_b(exp_resp, b);
      end
    end
    if (q_valid && q_ready) begin
      q_log.push_back(q);
    end
  end

  task automatic send_read(axi_ax_t ax);
    int unsigned cycles;
    int unsigned i;
    addr_t       nb;
    addr_t       base;
    addr_t       a;
    nb   = addr_t'(2 ** ax.size);
    base = ax.addr - (ax.addr % nb);
    for (i = 0; i <= ax.len; i++) begin
      a = (i == 0) ? ax.addr : base + addr_t'(i) * nb;
      exp_r.push_back(ref_read(a, ax.id, i == ax.len));
    end
    ar       = ax;
    ar_valid = 1'b1;
    cycles   = 0;
    @(negedge clk);
    while (!ar_ready && cycles < TimeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!ar_ready) abort_run("AR was never accepted");
    @(posedge clk);
    #(DriveDelay);
    ar_valid = 1'b0;
  endtask

  task automatic send_write(axi_ax_t ax);
    int unsigned cycles;
    int unsigned i;
    addr_t       nb;
    addr_t       base;
    addr_t       a;
    axi_b_t      resp;
    nb        = addr_t'(2 ** ax.size);
    base      = ax.addr - (ax.addr % nb);
    resp.id   = ax.id;
    resp.resp = ax.addr[31] ? SLVERR : OKAY;
    exp_b.push_back(resp);
    for (i = 0; i <= ax.len; i++) begin
      a = (i == 0) ? ax.addr : base + addr_t'(i) * nb;
      if (!a[31]) write_shadow(a, beat_data[i], beat_strb[i]);
      w.data  = beat_data[i];
      w.strb  = beat_strb[i];
      w.last  = (i == ax.len);
      w_valid = 1'b1;
      if (i == 0) begin
        aw       = ax;
        aw_valid = 1'b1;
      end
      cycles = 0;
      @(negedge clk);
      while (!w_ready && cycles < TimeoutCycles) begin
        @(negedge clk);
        cycles++;
      end
      if (!w_ready) abort_run("W beat was never accepted");
      // AW is taken together with the first W beat.
      if (i == 0) begin
        compare_field("aw_ready_o", 1'b1, aw_ready);
      end
      @(posedge clk);
      #(DriveDelay);
      aw_valid = 1'b0;
      w_valid  = 1'b0;
    end
  endtask

  // Waits for all responses, checks that busy has dropped, then realigns to the drive point.
  task automatic wait_idle(string what);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk);
    while ((exp_r.size() != 0 || exp_b.size() != 0) && cycles < TimeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_r.size() != 0 || exp_b.size() != 0) begin
      abort_run({"responses still pending after ", what});
    end
    @(negedge clk);
    compare_field("busy_o", 1'b0, busy);
    @(posedge clk);
    #(DriveDelay);
  endtask

  task automatic end_test(string name, int unsigned errs_before);
    test_count++;
    $display("Test %0d %s: %s", test_count, name, (err_count == errs_before) ? "ok" : "FAILED");
  endtask

  initial begin
    int unsigned errs;
    int unsigned b_before;
    int unsigned i;
    arst_n   = 1'b0;
    aw_valid = 1'b0;
    aw       = '0;
    w_valid  = 1'b0;
    w        = '0;
    ar_valid = 1'b0;
    ar       = '0;
    b_ready  = 1'b1;
    r_ready  = 1'b1;
    repeat (3) @(posedge clk);
    #(DriveDelay);
    arst_n = 1'b1;
    compare_field("busy_o after reset", 1'b0, busy);

    errs = err_count;
    beat_data[0] = 32'hcafe_f00d;
    beat_strb[0] = 4'hf;
    send_write(make_ax(4'h3, 32'h0000_0100, 8'd0, 4'd0));
    wait_idle("full word write");
    beat_data[0] = 32'h1122_3344;
    beat_strb[0] = 4'b0101;
    send_write(make_ax(4'h3, 32'h0000_0100, 8'd0, 4'd0));
    wait_idle("partial write");
    send_read(make_ax(4'h3, 32'h0000_0100, 8'd0, 4'd0));
    wait_idle("single read");
    end_test("single write and read", errs);

    errs = err_count;
    q_log.delete();
    for (i = 0; i < 4; i++) begin
      beat_data[i] = 32'ha000_0000 + i * 32'h0101_0101;
      beat_strb[i] = 4'hf;
    end
    beat_strb[0] = 4'b1100;
    send_write(make_ax(4'h5, 32'h0000_1006, 8'd3, 4'd0));
    wait_idle("write burst");
    if (q_log.size() != 4) begin
      err_count++;
      $display("Write burst produced %0d memory requests instead of four", q_log.size());
    end else begin
      check_q(make_q(32'h0000_1006, 1'b1, beat_data[0], 4'b1100), q_log[0]);
      check_q(make_q(32'h0000_1008, 1'b1, beat_data[1], 4'hf), q_log[1]);
      check_q(make_q(32'h0000_100c, 1'b1, beat_data[2], 4'hf), q_log[2]);
      check_q(make_q(32'h0000_1010, 1'b1, beat_data[3], 4'hf), q_log[3]);
    end
    send_read(make_ax(4'h6, 32'h0000_1006, 8'd3, 4'd0));
    wait_idle("read burst");
    end_test("unaligned INCR bursts", errs);

    errs = err_count;
    b_before = b_count;
    beat_data[0] = 32'hdead_0001;
    beat_data[1] = 32'hdead_0002;
    beat_strb[0] = 4'hf;
    beat_strb[1] = 4'hf;
    send_write(make_ax(4'h7, 32'h8000_0100, 8'd1, 4'd0));
    wait_idle("error write burst");
    compare_field("B count of one write burst", 1, b_count - b_before);
    send_read(make_ax(4'h8, 32'h8000_0100, 8'd1, 4'd0));
    wait_idle("error read burst");
    end_test("downstream error", errs);

    errs = err_count;
    q_log.delete();
    beat_data[0] = 32'h0bad_beef;
    beat_strb[0] = 4'hf;
    fork
      send_write(make_ax(4'h9, 32'h0000_4000, 8'd0, 4'hf));
      send_read(make_ax(4'ha, 32'h0000_4010, 8'd0, 4'h1));
    join
    wait_idle("write QoS higher");
    check_q(make_q(32'h0000_4000, 1'b1, 32'h0bad_beef, 4'hf), q_log[0]);
    q_log.delete();
    beat_data[0] = 32'h600d_cafe;
    fork
      send_write(make_ax(4'h9, 32'h0000_4004, 8'd0, 4'h1));
      send_read(make_ax(4'ha, 32'h0000_4000, 8'd0, 4'hf));
    join
    wait_idle("read QoS higher");
    check_q(make_q(32'h0000_4000, 1'b0, '0, '0), q_log[0]);
    end_test("QoS arbitration", errs);

    errs = err_count;
    random_r_ready = 1'b1;
    send_read(make_ax(4'h1, 32'h0000_2000, 8'd3, 4'd0));
    send_read(make_ax(4'h2, 32'h0000_2046, 8'd3, 4'd0));
    send_read(make_ax(4'h3, 32'h0000_1004, 8'd3, 4'd0));
    send_read(make_ax(4'h4, 32'h0000_3010, 8'd3, 4'd0));
    wait_idle("overlapping reads");
    random_r_ready = 1'b0;
    end_test("R back-pressure", errs);

    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
common/axi_reqrsp_pkg.sv
burst/axi_rd_burst.sv
burst/axi_wr_burst.sv
logic/ax_arbiter.sv
logic/resp_meta_fifo.sv
logic/resp_router.sv
logic/axi_to_reqrsp.sv
test/tb_reqrsp_mem.sv
test/tb_axi_to_reqrsp.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_to_reqrsp
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(BUILD_DIR)
